//--- bp_patterns.txt
# stall valid taken pred_taken res_pc res_target res_pred_target res_ghr (stimulus, hex)
# exp_pc exp_pred_taken exp_pred_target exp_ghr exp_flush (expected before the rising edge)
0 0 0 0 00000000 00000000 00000000 00 00000000 0 00000004 00 0
0 0 0 0 00000000 00000000 00000000 00 00000004 0 00000008 00 0
1 0 0 0 00000000 00000000 00000000 00 00000008 0 0000000c 00 0
1 0 0 0 00000000 00000000 00000000 00 00000008 0 0000000c 00 0
0 0 0 0 00000000 00000000 00000000 00 00000008 0 0000000c 00 0
0 0 0 0 00000000 00000000 00000000 00 0000000c 0 00000010 00 0
1 1 1 0 00000200 00000300 00000204 03 00000010 0 00000014 00 1
0 0 0 0 00000000 00000000 00000000 00 00000300 0 00000304 07 0
0 1 0 1 00000500 00000600 00000600 0a 00000304 0 00000308 07 1
0 0 0 0 00000000 00000000 00000000 00 00000504 0 00000508 14 0
0 1 0 0 00000700 00000800 00000704 11 00000508 0 0000050c 14 0
0 1 1 1 00000900 00000a00 00000a00 02 0000050c 0 00000510 02 0
0 0 0 0 00000000 00000000 00000000 00 00000510 0 00000514 05 0
0 1 1 0 00000520 00000580 00000524 1f 00000514 0 00000518 05 1
0 1 1 0 00000520 00000580 00000524 1f 00000580 0 00000584 1f 1
0 1 1 0 000005f0 00000520 000005f4 0f 00000580 0 00000584 1f 1
0 0 0 0 00000000 00000000 00000000 00 00000520 1 00000580 1f 0
0 1 0 1 00000520 00000580 00000580 1f 00000580 0 00000584 1f 1
0 1 1 0 000005f0 00000520 000005f4 0f 00000524 0 00000528 1e 1
0 1 0 1 00000520 00000580 00000580 1f 00000520 1 00000580 1f 1
0 1 1 0 000005f0 00000520 000005f4 0f 00000524 0 00000528 1e 1
0 0 0 0 00000000 00000000 00000000 00 00000520 0 00000524 1f 0
0 1 1 1 00000520 000005a0 00000580 1f 00000524 0 00000528 1f 1
0 1 1 0 000005f0 00000520 000005f4 0f 000005a0 0 000005a4 1f 1
0 0 0 0 00000000 00000000 00000000 00 00000520 1 000005a0 1f 0
1 0 0 0 00000000 00000000 00000000 00 000005a0 0 000005a4 1f 0
0 1 1 1 00000520 000005a0 000005a0 1f 000005a0 0 000005a4 1f 0
0 0 0 0 00000000 00000000 00000000 00 000005a4 0 000005a8 1f 0
1 1 0 0 000005c0 00000000 000005c4 1f 000005a8 0 000005ac 1f 0
0 0 0 0 00000000 00000000 00000000 00 000005a8 0 000005ac 1e 0
0 0 0 0 00000000 00000000 00000000 00 000005ac 0 000005b0 1e 0
0 0 0 0 00000000 00000000 00000000 00 000005b0 0 000005b4 1e 0

//--- files.f
bp_pkg.sv
bp_if.sv
btb.sv
pht.sv
fetch_ctrl.sv
gshare_fetch.sv
tb_gshare_fetch.sv

//--- Makefile
TOP := tb_gshare_fetch

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module $(TOP) -f files.f
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb_gshare_fetch.sv
`timescale 1ns/100ps

module tb_gshare_fetch import bp_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_LINES    = 256;
    localparam int FIELDS       = 13;   // Columns per pattern line

    typedef logic [DEF_HIST_W-1:0] ghr_t;

    logic  clk_i;
    logic  rst_ni;
    logic  stall_i;
    logic  res_valid_i;
    logic  res_taken_i;
    logic  res_pred_taken_i;
    addr_t res_pc_i;
    addr_t res_target_i;
    addr_t res_pred_target_i;
    ghr_t  res_ghr_i;
    addr_t pc_o;
    addr_t pred_target_o;
    logic  pred_taken_o;
    logic  flush_o;
    ghr_t  ghr_o;

    // Stimulus columns
    logic  stall_v       [MAX_LINES];
    logic  valid_v       [MAX_LINES];
    logic  taken_v       [MAX_LINES];
    logic  ptaken_v      [MAX_LINES];
    addr_t rpc_v         [MAX_LINES];
    addr_t rtarget_v     [MAX_LINES];
    addr_t rptarget_v    [MAX_LINES];
    ghr_t  rghr_v        [MAX_LINES];

    // Expected columns
    addr_t exp_pc_v      [MAX_LINES];
    logic  exp_ptaken_v  [MAX_LINES];
    addr_t exp_ptarget_v [MAX_LINES];
    ghr_t  exp_ghr_v     [MAX_LINES];
    logic  exp_flush_v   [MAX_LINES];

    int n_lines;
    int cur_line;
    int cycles;
    int cycle_limit;
    int checks;
    int addr_errors;
    int flag_errors;
    int ghr_errors;
    logic load_ok;

    gshare_fetch gshare_fetch_inst (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .stall_i           (stall_i),
        .res_valid_i       (res_valid_i),
        .res_taken_i       (res_taken_i),
        .res_pred_taken_i  (res_pred_taken_i),
        .res_pc_i          (res_pc_i),
        .res_target_i      (res_target_i),
        .res_pred_target_i (res_pred_target_i),
        .res_ghr_i         (res_ghr_i),
        .pc_o              (pc_o),
        .pred_target_o     (pred_target_o),
        .pred_taken_o      (pred_taken_o),
        .flush_o           (flush_o),
        .ghr_o             (ghr_o)
    );

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    // Run limit from the pattern count
    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: run still going after %0d clock cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            addr_errors++;
            $display("mismatch at time %0t: %s is %h, expected %h (pattern line %0d)",
                     $time, name, got, exp, cur_line);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            flag_errors++;
            $display("mismatch at time %0t: %s is %b, expected %b (pattern line %0d)",
                     $time, name, got, exp, cur_line);
        end
    endtask

    task automatic check_ghr(input string name, input ghr_t got, input ghr_t exp);
        checks++;
        if (got !== exp) begin
            ghr_errors++;
            $display("mismatch at time %0t: %s is %h, expected %h (pattern line %0d)",
                     $time, name, got, exp, cur_line);
        end
    endtask

    // Comment and blank lines are skipped
    task automatic load_patterns(output logic ok);
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] f [FIELDS];
        ok      = 1'b1;
        n_lines = 0;
        fd      = $fopen("bp_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open the pattern file bp_patterns.txt");
            ok = 1'b0;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                              f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                              f[7], f[8], f[9], f[10], f[11], f[12]);
                if (cnt != FIELDS || n_lines >= MAX_LINES) begin
                    $display("pattern line %0d is malformed or the table is full", n_lines + 1);
                    ok = 1'b0;
                    break;
                end
                stall_v[n_lines]       = f[0][0];
                valid_v[n_lines]       = f[1][0];
                taken_v[n_lines]       = f[2][0];
                ptaken_v[n_lines]      = f[3][0];
                rpc_v[n_lines]         = f[4];
                rtarget_v[n_lines]     = f[5];
                rptarget_v[n_lines]    = f[6];
                rghr_v[n_lines]        = f[7][DEF_HIST_W-1:0];
                exp_pc_v[n_lines]      = f[8];
                exp_ptaken_v[n_lines]  = f[9][0];
                exp_ptarget_v[n_lines] = f[10];
                exp_ghr_v[n_lines]     = f[11][DEF_HIST_W-1:0];
                exp_flush_v[n_lines]   = f[12][0];
                n_lines++;
            end
            $fclose(fd);
            if (ok && n_lines == 0) begin
                $display("the pattern file bp_patterns.txt holds no pattern lines");
                ok = 1'b0;
            end
        end
    endtask

    task automatic apply_line(input int i);
        stall_i           = stall_v[i];
        res_valid_i       = valid_v[i];
        res_taken_i       = taken_v[i];
        res_pred_taken_i  = ptaken_v[i];
        res_pc_i          = rpc_v[i];
        res_target_i      = rtarget_v[i];
        res_pred_target_i = rptarget_v[i];
        res_ghr_i         = rghr_v[i];
    endtask

    task automatic check_line(input int i);
        cur_line = i + 1;
        check_addr("pc_o", pc_o, exp_pc_v[i]);
        check_flag("pred_taken_o", pred_taken_o, exp_ptaken_v[i]);
        check_addr("pred_target_o", pred_target_o, exp_ptarget_v[i]);
        check_ghr("ghr_o", ghr_o, exp_ghr_v[i]);
        check_flag("flush_o", flush_o, exp_flush_v[i]);
    endtask

    initial begin
        clk_i       = 1'b0;
        rst_ni      = 1'b0;
        cycles      = 0;
        cycle_limit = RESET_CYCLES + 20;
        checks      = 0;
        addr_errors = 0;
        flag_errors = 0;
        ghr_errors  = 0;
        cur_line    = 0;
        // Quiet back end until the table is loaded
        stall_i           = 1'b0;
        res_valid_i       = 1'b0;
        res_taken_i       = 1'b0;
        res_pred_taken_i  = 1'b0;
        res_pc_i          = '0;
        res_target_i      = '0;
        res_pred_target_i = '0;
        res_ghr_i         = '0;
        load_patterns(load_ok);
        if (!load_ok) begin
            $display("SOME TESTS FAILED");
            $finish;
        end else begin
            cycle_limit = n_lines + RESET_CYCLES + 20;
            repeat (RESET_CYCLES) @(posedge clk_i);
            @(negedge clk_i);
            rst_ni = 1'b1;
            for (int i = 0; i < n_lines; i++) begin
                apply_line(i);
                #(CLK_PERIOD/2 - 2);   // Just ahead of the rising edge
                check_line(i);
                @(negedge clk_i);
            end
            $display("checks %0d, errors %0d (address %0d, flag %0d, history %0d)",
                     checks, addr_errors + flag_errors + ghr_errors,
                     addr_errors, flag_errors, ghr_errors);
            if (addr_errors + flag_errors + ghr_errors == 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

//--- gshare_fetch.sv
`timescale 1ns/100ps

module gshare_fetch import bp_pkg::*; #(
    parameter int BTB_IDX_W = DEF_BTB_IDX_W,
    parameter int HIST_W    = DEF_HIST_W
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              stall_i,             // Holds the PC
    input  logic              res_valid_i,         // Resolve strobe
    input  logic              res_taken_i,
    input  logic              res_pred_taken_i,
    input  addr_t             res_pc_i,
    input  addr_t             res_target_i,
    input  addr_t             res_pred_target_i,
    input  logic [HIST_W-1:0] res_ghr_i,           // History seen at fetch
    output addr_t             pc_o,
    output addr_t             pred_target_o,
    output logic              pred_taken_o,
    output logic              flush_o,
    output logic [HIST_W-1:0] ghr_o
);

    lookup_if  #(.HIST_W(HIST_W)) lookup_bus ();
    resolve_if #(.HIST_W(HIST_W)) resolve_bus ();

    // Resolve report from the back end
    assign resolve_bus.valid       = res_valid_i;
    assign resolve_bus.pc          = res_pc_i;
    assign resolve_bus.taken       = res_taken_i;
    assign resolve_bus.target      = res_target_i;
    assign resolve_bus.pred_taken  = res_pred_taken_i;
    assign resolve_bus.pred_target = res_pred_target_i;
    assign resolve_bus.ghr         = res_ghr_i;

    btb #(
        .BTB_IDX_W (BTB_IDX_W)
    ) btb_inst (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .lookup  (lookup_bus),
        .resolve (resolve_bus)
    );

    pht #(
        .HIST_W (HIST_W)
    ) pht_inst (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .lookup  (lookup_bus),
        .resolve (resolve_bus)
    );

    fetch_ctrl #(
        .HIST_W (HIST_W)
    ) fetch_ctrl_inst (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .stall_i       (stall_i),
        .lookup        (lookup_bus),
        .resolve       (resolve_bus),
        .pc_o          (pc_o),
        .pred_target_o (pred_target_o),
        .pred_taken_o  (pred_taken_o),
        .flush_o       (flush_o),
        .ghr_o         (ghr_o)
    );

endmodule

//--- fetch_ctrl.sv
`timescale 1ns/100ps

module fetch_ctrl import bp_pkg::*; #(
    parameter int HIST_W = DEF_HIST_W
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              stall_i,
    lookup_if.ctrl            lookup,
    resolve_if.ctrl           resolve,
    output addr_t             pc_o,
    output addr_t             pred_target_o,
    output logic              pred_taken_o,
    output logic              flush_o,
    output logic [HIST_W-1:0] ghr_o
);

    localparam addr_t INSN_BYTES = addr_t'(4);

    typedef logic [HIST_W-1:0] ghr_t;

    addr_t pc_q;
    addr_t pc_d;
    addr_t pc_plus4;
    addr_t redirect_pc;
    addr_t pred_target;
    ghr_t  ghr_q;
    ghr_t  ghr_d;
    logic  pred_taken;
    logic  dir_miss;
    logic  tgt_miss;
    logic  mispredict;

    // Lookup always describes the current PC
    assign lookup.pc  = pc_q;
    assign lookup.ghr = ghr_q;

    assign pc_plus4    = pc_q + INSN_BYTES;
    assign pred_taken  = lookup.hit && lookup.taken;   // Needs both a target and a taken counter
    assign pred_target = pred_taken ? lookup.target : pc_plus4;

    // Wrong direction, or right direction but wrong target
    assign dir_miss   = resolve.taken != resolve.pred_taken;
    assign tgt_miss   = resolve.taken && resolve.pred_taken
                        && (resolve.target != resolve.pred_target);
    assign mispredict = resolve.valid && (dir_miss || tgt_miss);

    assign redirect_pc = resolve.taken ? resolve.target : resolve.pc + INSN_BYTES;

    // Redirect beats stall, stall beats prediction
    always_comb begin
        if (mispredict) begin
            pc_d = redirect_pc;
        end else if (stall_i) begin
            pc_d = pc_q;
        end else begin
            pc_d = pred_target;
        end
    end

    // History rebuilt from the snapshot plus the real outcome
    assign ghr_d = resolve.valid ? {resolve.ghr[HIST_W-2:0], resolve.taken} : ghr_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q  <= '0;
            ghr_q <= '0;
        end else begin
            pc_q  <= pc_d;
            ghr_q <= ghr_d;
        end
    end

    assign pc_o          = pc_q;
    assign ghr_o         = ghr_q;
    assign pred_taken_o  = pred_taken;
    assign pred_target_o = pred_target;
    assign flush_o       = mispredict;   // Same cycle as the bad resolve

endmodule

//--- pht.sv
`timescale 1ns/100ps

module pht import bp_pkg::*; #(
    parameter int HIST_W = DEF_HIST_W
) (
    input logic    clk_i,
    input logic    rst_ni,
    lookup_if.pht  lookup,
    resolve_if.pht resolve
);

    localparam int ENTRIES = 1 << HIST_W;

    typedef logic [HIST_W-1:0] pht_idx_t;

    ctr_state_e ctr_q [ENTRIES];

    pht_idx_t   rd_idx;
    pht_idx_t   wr_idx;
    ctr_state_e wr_state;

    // Saturating step of one counter toward the resolved outcome
    function automatic ctr_state_e step(ctr_state_e cur, logic taken);
        ctr_state_e nxt;
        case (cur)
            STRONG_NT: nxt = taken ? WEAK_NT  : STRONG_NT;
            WEAK_NT:   nxt = taken ? WEAK_T   : STRONG_NT;
            WEAK_T:    nxt = taken ? STRONG_T : WEAK_NT;
            STRONG_T:  nxt = taken ? STRONG_T : WEAK_T;
            default:   nxt = WEAK_NT;
        endcase
        return nxt;
    endfunction

    // Gshare index from word address and history
    assign rd_idx = lookup.pc[HIST_W+1:2] ^ lookup.ghr;
    assign wr_idx = resolve.pc[HIST_W+1:2] ^ resolve.ghr;   // Uses the fetch time snapshot

    assign lookup.taken = (ctr_q[rd_idx] >= WEAK_T);   // Upper half of the encoding

    assign wr_state = step(ctr_q[wr_idx], resolve.taken);

    // All counters start weakly not taken
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < ENTRIES; i++) begin
                ctr_q[i] <= WEAK_NT;
            end
        end else if (resolve.valid) begin
            ctr_q[wr_idx] <= wr_state;
        end
    end

endmodule

//--- btb.sv
`timescale 1ns/100ps

module btb import bp_pkg::*; #(
    parameter int BTB_IDX_W = DEF_BTB_IDX_W
) (
    input logic   clk_i,
    input logic   rst_ni,
    lookup_if.btb lookup,
    resolve_if.btb resolve
);

    localparam int ENTRIES = 1 << BTB_IDX_W;
    localparam int TAG_W   = ADDR_W - BTB_IDX_W - 2;   // Bits above index and byte offset

    typedef logic [BTB_IDX_W-1:0] btb_idx_t;
    typedef logic [TAG_W-1:0]     btb_tag_t;

    logic [ENTRIES-1:0] valid_q;
    btb_tag_t           tag_q    [ENTRIES];
    addr_t              target_q [ENTRIES];

    btb_idx_t rd_idx;
    btb_tag_t rd_tag;
    btb_idx_t wr_idx;
    btb_tag_t wr_tag;
    logic     wr_en;

    // Address split for the fetch PC
    assign rd_idx = lookup.pc[BTB_IDX_W+1:2];
    assign rd_tag = lookup.pc[ADDR_W-1:BTB_IDX_W+2];

    // Address split for the resolving PC
    assign wr_idx = resolve.pc[BTB_IDX_W+1:2];
    assign wr_tag = resolve.pc[ADDR_W-1:BTB_IDX_W+2];

    // Only taken branches allocate
    assign wr_en = resolve.valid && resolve.taken;

    // Read sees the table as it stood before this edge
    assign lookup.hit    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign lookup.target = target_q[rd_idx];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Tag and target storage
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= resolve.target;   // Overwrites a stale target too
        end
    end

endmodule

//--- bp_if.sv
`timescale 1ns/100ps

// Fetch side lookup, resolved within the cycle
interface lookup_if import bp_pkg::*; #(
    parameter int HIST_W = DEF_HIST_W
);

    addr_t             pc;      // Current fetch PC
    logic [HIST_W-1:0] ghr;     // Current global history
    logic              hit;     // BTB tag match
    addr_t             target;  // BTB stored target
    logic              taken;   // Counter says taken

    modport ctrl (output pc, ghr, input hit, target, taken);
    modport btb  (input pc, output hit, target);
    modport pht  (input pc, ghr, output taken);

endinterface

// Resolved branch report from the back end
interface resolve_if import bp_pkg::*; #(
    parameter int HIST_W = DEF_HIST_W
);

    logic              valid;        // One cycle per resolved branch or jump
    addr_t             pc;
    logic              taken;        // Actual outcome
    addr_t             target;       // Actual target
    logic              pred_taken;   // Prediction handed out at fetch
    addr_t             pred_target;
    logic [HIST_W-1:0] ghr;          // History snapshot taken at fetch

    modport btb  (input valid, pc, taken, target);
    modport pht  (input valid, pc, taken, ghr);
    modport ctrl (input valid, pc, taken, target, pred_taken, pred_target, ghr);

endinterface

//--- bp_pkg.sv
package bp_pkg;

    // Instruction address width
    localparam int ADDR_W = 32;

    // Defaults picked up by the top level
    localparam int DEF_BTB_IDX_W = 6;   // 64 BTB entries
    localparam int DEF_HIST_W    = 5;   // 32 PHT entries

    typedef logic [ADDR_W-1:0] addr_t;

    // 2-bit saturating counter, ordered from not taken to taken
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } ctr_state_e;

endpackage
